// File: dv/hazardSocBus_chk.sv
// Bus protocol checker
// Concurrent assertions on the splitter selects, the UART idle level
// and the ready state coming out of reset
`default_nettype none

module hazardSocBus_chk (
    input logic HCLK,
    input logic arstN,
    input logic ramSel,
    input logic gpioSel,
    input logic uartSel,
    input logic hReady,
    input logic uartTx,
    input logic uartBusy
);

    // At most one slave decoded per address phase
    selOneHot: assert property (@(posedge HCLK) disable iff (!arstN)
        $onehot0({uartSel, gpioSel, ramSel}))
        else $error("More than one slave select is active");

    // Line idles high between frames
    txIdleHigh: assert property (@(posedge HCLK) disable iff (!arstN)
        !uartBusy |-> uartTx)
        else $error("uartTx is low while the transmitter is idle");

    // No data phase can be pending right after reset
    readyAfterReset: assert property (@(posedge HCLK)
        $rose(arstN) |-> hReady)
        else $error("hReady is low in the first cycle after reset");

endmodule

`default_nettype wire

// File: dv/hazardSocTb.sv
// hazardSoc testbench
// Single AHB-Lite master with LFSR stimulus, a RAM, GPIO and UART model,
// and a bit-level monitor on uartTx
`default_nettype none

module hazardSocTb import socPkg::*; ();

    localparam int ramWords   = 64;
    localparam int baudDiv    = 8;
    localparam int idxBits    = $clog2(ramWords);
    localparam int nRamOps    = 300;
    localparam int nGpioOps   = 6;
    localparam int nUartBytes = 6;
    localparam int nXfers     = 3 * ramWords + nRamOps + 5 * nGpioOps + 2 * nUartBytes + 16;
    // Any transfer may wait out one full UART frame
    localparam longint watchdogTime = longint'(nXfers) * (10 * baudDiv + 4) * 10;
    localparam ahbReq_t idleReq = '{hAddr: 32'h0, hTrans: IDLE, hSize: WORD, hWrite: 1'b0};

    typedef struct packed {
        logic [31:0] addr;
        hSize_t      size;
        logic        write;
        logic [31:0] data;
    } xfer_t;

    logic        HCLK;
    logic        arstN;
    ahbReq_t     busReq;
    logic [31:0] hWData;
    logic [31:0] gpioIn;
    logic        hReady;
    logic [31:0] hRData;
    logic        uartTx;
    logic [31:0] gpioOut;
    logic [31:0] gpioOe;

    // Reference model
    logic [31:0] ramModel [ramWords];
    logic [31:0] gpioOutM;
    logic [31:0] gpioOeM;
    logic [31:0] gpioInM;
    logic [7:0]  uartExpQ [$];
    int          uartWritten;
    int          uartSeen;
    logic        rxActive;   // Monitor is inside a frame
    xfer_t       xferQ [$];  // Transfers waiting for their address phase
    logic [31:0] lfsr;

    hazardSoc #(.ramWords(ramWords), .baudDiv(baudDiv)) i_dut (
        .HCLK    (HCLK),
        .arstN   (arstN),
        .busReq  (busReq),
        .hWData  (hWData),
        .gpioIn  (gpioIn),
        .hReady  (hReady),
        .hRData  (hRData),
        .uartTx  (uartTx),
        .gpioOut (gpioOut),
        .gpioOe  (gpioOe)
    );

    bind hazardSoc hazardSocBus_chk i_chk (
        .HCLK     (HCLK),
        .arstN    (arstN),
        .ramSel   (ramSel),
        .gpioSel  (gpioSel),
        .uartSel  (uartSel),
        .hReady   (hReady),
        .uartTx   (uartTx),
        .uartBusy (i_uartTx.busy)
    );

    always #5 HCLK = ~HCLK;

    task automatic abortRun();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
            abortRun();
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = 32'h0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return val;
    endfunction

    // Lanes covered by an aligned transfer of 1 << size bytes
    function automatic logic [3:0] laneMask(input hSize_t size, input logic [1:0] low);
        int         nBytes;
        int         base;
        logic [3:0] mask;
        nBytes = 1 << int'(size);
        base   = int'(low) & ~(nBytes - 1);
        for (int i = 0; i < 4; i++) mask[i] = (i >= base) && (i < base + nBytes);
        return mask;
    endfunction

    function automatic ahbReq_t toReq(input xfer_t x);
        return '{hAddr: x.addr, hTrans: NONSEQ, hSize: x.size, hWrite: x.write};
    endfunction

    task automatic queueXfer(input logic [31:0] addr, input hSize_t size,
                             input logic write, input logic [31:0] data);
        xferQ.push_back('{addr: addr, size: size, write: write, data: data});
    endtask

    // ----------------------------------------
    // Data phase completion against the model
    // ----------------------------------------
    task automatic finishData(input xfer_t x, input logic [31:0] rd);
        logic [3:0]  slot;
        logic [7:0]  off;
        logic [3:0]  lanes;
        logic [31:0] expVal;
        int          idx;
        slot   = x.addr[31:28];
        off    = x.addr[7:0];
        idx    = int'(x.addr[idxBits+1:2]);
        lanes  = laneMask(x.size, x.addr[1:0]);
        expVal = 32'h0;  // Unmapped reads return zero
        if (x.write) begin
            if (slot == slotRam) begin
                for (int i = 0; i < 4; i++) begin
                    if (lanes[i]) ramModel[idx][8*i +: 8] = x.data[8*i +: 8];
                end
            end else if (slot == slotGpio && off == regGpioOut) begin
                gpioOutM = x.data;
            end else if (slot == slotGpio && off == regGpioOe) begin
                gpioOeM = x.data;
            end else if (slot == slotUart && off == regUartData) begin
                uartExpQ.push_back(x.data[7:0]);
                uartWritten++;
            end
        end else begin
            if (slot == slotRam) expVal = ramModel[idx];
            else if (slot == slotGpio && off == regGpioOut) expVal = gpioOutM;
            else if (slot == slotGpio && off == regGpioOe) expVal = gpioOeM;
            else if (slot == slotGpio && off == regGpioIn) expVal = gpioInM;
            else if (slot == slotUart && off == regUartStatus) begin
                expVal = {31'h0, uartWritten > uartSeen};  // Frame still pending
            end
            checkEq("hRData", expVal, rd);
        end
    endtask

    // Pipelined master where the next address overlaps the current data phase
    task automatic runQueue();
        xfer_t       addrX;
        xfer_t       dataX;
        logic        addrValid;
        logic        dataValid;
        logic        rdy;
        logic [31:0] rd;
        addrX     = '0;
        dataX     = '0;
        addrValid = 1'b0;
        dataValid = 1'b0;
        do begin
            @(negedge HCLK);
            rdy = hReady;
            rd  = hRData;
            if (rdy) begin
                if (dataValid) finishData(dataX, rd);
                dataX     = addrX;
                dataValid = addrValid;
                addrValid = (xferQ.size() > 0);
                if (addrValid) addrX = xferQ.pop_front();
            end
            @(posedge HCLK);
            if (rdy) begin  // Hold everything while stalled
                busReq <= addrValid ? toReq(addrX) : idleReq;
                hWData <= dataX.write ? dataX.data : 32'h0;
            end
        end while (addrValid || dataValid);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : mainSeq
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] lastAddr;
        hSize_t      sz;
        HCLK        = 1'b0;
        arstN       = 1'b0;
        busReq      = idleReq;
        hWData      = 32'h0;
        gpioIn      = 32'h0;
        lfsr        = 32'h7fd6;
        gpioOutM    = 32'h0;
        gpioOeM     = 32'h0;
        gpioInM     = 32'h0;
        uartWritten = 0;
        uartSeen    = 0;
        lastAddr    = 32'h0;
        repeat (3) @(posedge HCLK);
        arstN <= 1'b1;
        @(negedge HCLK);
        checkEq("hReady", 32'h1, {31'h0, hReady});
        checkEq("uartTx", 32'h1, {31'h0, uartTx});
        checkEq("gpioOut", 32'h0, gpioOut);
        checkEq("gpioOe", 32'h0, gpioOe);

        // Fill pattern over the whole address and then random traffic
        for (int w = 0; w < ramWords; w++) begin
            addr = 32'(w) << 2;
            queueXfer(addr, WORD, 1'b1, {addr[15:0], addr[31:16]} ^ 32'h9E37_79B9);
        end
        for (int n = 0; n < nRamOps; n++) begin
            r = randBits(idxBits + 7);
            if (r[1:0] == 2'd0) begin
                queueXfer({lastAddr[31:2], 2'b00}, WORD, 1'b0, 32'h0);
            end else begin
                sz   = (r[3:2] == 2'd0) ? BYTE : (r[3:2] == 2'd1) ? HALF : WORD;
                addr = 32'h0;
                addr[idxBits+1:2] = r[idxBits+6:7];
                if (sz == BYTE) addr[1:0] = r[6:5];
                else if (sz == HALF) addr[1] = r[6];
                queueXfer(addr, sz, r[4], randBits(32));
                lastAddr = addr;
            end
        end
        runQueue();

        for (int n = 0; n < nGpioOps; n++) begin
            queueXfer({slotGpio, 20'h0, regGpioOut}, WORD, 1'b1, randBits(32));
            queueXfer({slotGpio, 20'h0, regGpioOe}, WORD, 1'b1, randBits(32));
            queueXfer({slotGpio, 20'h0, regGpioOut}, WORD, 1'b0, 32'h0);
            queueXfer({slotGpio, 20'h0, regGpioOe}, WORD, 1'b0, 32'h0);
            runQueue();
            @(negedge HCLK);
            checkEq("gpioOut", gpioOutM, gpioOut);
            checkEq("gpioOe", gpioOeM, gpioOe);
            @(posedge HCLK);
            gpioInM = randBits(32);
            gpioIn <= gpioInM;
            repeat (2) @(posedge HCLK);  // Through the synchronizer
            queueXfer({slotGpio, 20'h0, regGpioIn}, WORD, 1'b0, 32'h0);
            runQueue();
        end

        // Back-to-back bytes with a status read after each
        for (int n = 0; n < nUartBytes; n++) begin
            queueXfer({slotUart, 20'h0, regUartData}, WORD, 1'b1, randBits(8));
            queueXfer({slotUart, 20'h0, regUartStatus}, WORD, 1'b0, 32'h0);
        end
        runQueue();
        while (uartSeen < nUartBytes) @(negedge HCLK);
        repeat (baudDiv) @(posedge HCLK);
        queueXfer({slotUart, 20'h0, regUartStatus}, WORD, 1'b0, 32'h0);
        runQueue();

        // Unmapped slots and then a read back of everything
        for (int n = 0; n < 4; n++) begin
            r    = randBits(26);
            addr = {4'hA + 4'(n), r[25:0], 2'b00};
            queueXfer(addr, WORD, 1'b1, randBits(32));
            queueXfer(addr, WORD, 1'b0, 32'h0);
        end
        for (int w = 0; w < ramWords; w++) queueXfer(32'(w) << 2, WORD, 1'b0, 32'h0);
        queueXfer({slotGpio, 20'h0, regGpioOut}, WORD, 1'b0, 32'h0);
        queueXfer({slotGpio, 20'h0, regGpioOe}, WORD, 1'b0, 32'h0);
        runQueue();
        @(negedge HCLK);
        checkEq("gpioOut", gpioOutM, gpioOut);
        checkEq("gpioOe", gpioOeM, gpioOe);

        if (!rxActive) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("UART line started a frame that was never written");
            abortRun();
        end
    end

    // ----------------------------------------
    // UART monitor sampling mid-bit
    // ----------------------------------------
    initial begin : uartMonitor
        logic [7:0] rxByte;
        rxActive = 1'b0;
        @(posedge arstN);
        forever begin
            @(negedge HCLK);
            if (uartTx === 1'b0) begin
                rxActive = 1'b1;
                repeat (baudDiv / 2) @(negedge HCLK);
                checkEq("uartTx start bit", 32'h0, {31'h0, uartTx});
                for (int b = 0; b < 8; b++) begin
                    repeat (baudDiv) @(negedge HCLK);
                    rxByte[b] = uartTx;  // LSB first
                end
                repeat (baudDiv) @(negedge HCLK);
                checkEq("uartTx stop bit", 32'h1, {31'h0, uartTx});
                if (uartExpQ.size() == 0) begin
                    $display("UART monitor decoded a frame that was never written");
                    abortRun();
                end else begin
                    checkEq("uartTx byte", {24'h0, uartExpQ.pop_front()}, {24'h0, rxByte});
                    uartSeen++;
                end
                rxActive = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(watchdogTime);
        $display("Watchdog expired at %0t with transfers or frames outstanding", $time);
        abortRun();
    end

endmodule

`default_nettype wire

// File: hazardSoc.f
hdl/socPkg.sv
hdl/ahblSplitter.sv
hdl/ahblRam.sv
hdl/ahblGpio.sv
hdl/ahblUartTx.sv
hdl/hazardSoc.sv
dv/hazardSocBus_chk.sv
dv/hazardSocTb.sv

// File: hdl/ahblGpio.sv
// AHB-Lite GPIO port
// Output and output-enable registers plus a synchronized input,
// all 32 bits wide and accessed as whole words
`default_nettype none

module ahblGpio import socPkg::*; (
    input  logic        HCLK,
    input  logic        arstN,
    input  ahbReq_t     busReq,
    input  logic [31:0] hWData,
    input  logic        sel,
    input  logic        hReady,
    input  logic [31:0] gpioIn,
    output ahbRsp_t     rsp,
    output logic [31:0] gpioOut,
    output logic [31:0] gpioOe
);

    logic        accept;
    logic        dataWrite;
    logic [7:0]  dataOff;   // Register offset of the data phase
    logic [31:0] inMeta;
    logic [31:0] inSync;
    logic [31:0] rdData;

    assign accept = sel && hReady && busReq.hTrans[1];

    // ----------------------------------------
    // Bus side
    // ----------------------------------------
    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            dataWrite <= 1'b0;
        end else if (hReady) begin
            dataWrite <= accept && busReq.hWrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) dataOff <= busReq.hAddr[7:0];
    end

    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            gpioOut <= 32'h0;
            gpioOe  <= 32'h0;
        end else if (dataWrite && hReady) begin
            if (dataOff == regGpioOut) gpioOut <= hWData;
            if (dataOff == regGpioOe)  gpioOe  <= hWData;
        end
    end

    // Two-flop input synchronizer
    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            inMeta <= 32'h0;
            inSync <= 32'h0;
        end else begin
            inMeta <= gpioIn;
            inSync <= inMeta;
        end
    end

    always_comb begin
        case (dataOff)
            regGpioOut: rdData = gpioOut;
            regGpioOe:  rdData = gpioOe;
            regGpioIn:  rdData = inSync;
            default:    rdData = 32'h0;
        endcase
    end

    assign rsp = '{hRData: rdData, hReadyOut: 1'b1};  // Never stalls

endmodule

`default_nettype wire

// File: hdl/ahblRam.sv
// AHB-Lite RAM
// Zero-wait-state word memory with byte, halfword and word writes and
// forwarding of a pending write into the next read
`default_nettype none

module ahblRam import socPkg::*; #(
    parameter int ramWords = 1024
) (
    input  logic        HCLK,
    input  logic        arstN,
    input  ahbReq_t     busReq,
    input  logic [31:0] hWData,
    input  logic        sel,
    input  logic        hReady,
    output ahbRsp_t     rsp
);

    localparam int addrBits = (ramWords > 1) ? $clog2(ramWords) : 1;

    logic [31:0]         mem [ramWords];
    logic                accept;
    logic [addrBits-1:0] addrIdx;

    // Data phase state
    logic                dataWrite;
    logic [addrBits-1:0] dataIdx;
    hSize_t              dataSize;
    logic [1:0]          dataLow;
    logic [3:0]          laneEn;
    logic                wrNow;

    // Read path
    logic [31:0] rdWord;
    logic [31:0] fwdData;
    logic [3:0]  fwdLanes;
    logic [31:0] rdData;

    assign accept  = sel && hReady && busReq.hTrans[1];
    assign addrIdx = busReq.hAddr[addrBits+1:2];
    assign wrNow   = dataWrite && hReady;  // Data phase ends this edge

    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            dataWrite <= 1'b0;
            fwdLanes  <= 4'b0000;
        end else begin
            if (hReady) dataWrite <= accept && busReq.hWrite;
            if (accept) begin
                // Read of the word being written right now
                fwdLanes <= (wrNow && dataIdx == addrIdx) ? laneEn : 4'b0000;
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) begin
            dataIdx  <= addrIdx;
            dataSize <= busReq.hSize;
            dataLow  <= busReq.hAddr[1:0];
            fwdData  <= hWData;
        end
    end

    // ----------------------------------------
    // Byte lanes and memory array
    // ----------------------------------------
    always_comb begin
        case (dataSize)
            BYTE:    laneEn = 4'b0001 << dataLow;
            HALF:    laneEn = dataLow[1] ? 4'b1100 : 4'b0011;
            default: laneEn = 4'b1111;
        endcase
    end

    always_ff @(posedge HCLK) begin
        for (int i = 0; i < 4; i++) begin
            if (wrNow && laneEn[i]) mem[dataIdx][8*i +: 8] <= hWData[8*i +: 8];
        end
        if (accept) rdWord <= mem[addrIdx];  // Old value on a same-edge write
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdData[8*i +: 8] = fwdLanes[i] ? fwdData[8*i +: 8] : rdWord[8*i +: 8];
        end
    end

    assign rsp = '{hRData: rdData, hReadyOut: 1'b1};

endmodule

`default_nettype wire

// File: hdl/ahblSplitter.sv
// AHB-Lite splitter
// Decodes HADDR[31:28] into slave selects and merges the slave
// responses, following the data phase rather than the address phase
`default_nettype none

module ahblSplitter import socPkg::*; (
    input  logic        HCLK,
    input  logic        arstN,
    input  ahbReq_t     busReq,
    input  ahbRsp_t     ramRsp,
    input  ahbRsp_t     gpioRsp,
    input  ahbRsp_t     uartRsp,
    output logic        ramSel,
    output logic        gpioSel,
    output logic        uartSel,
    output logic        hReady,
    output logic [31:0] hRData
);

    logic [3:0] slot;
    logic       active;
    logic [2:0] dataSel;  // One-hot {uart, gpio, ram} of the data phase

    assign slot   = busReq.hAddr[31:28];
    assign active = busReq.hTrans[1];  // NONSEQ or SEQ

    // ----------------------------------------
    // Address phase decode
    // ----------------------------------------
    assign ramSel  = (slot == slotRam);
    assign gpioSel = (slot == slotGpio);
    assign uartSel = (slot == slotUart);

    // Slot follows the transfer into its data phase
    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            dataSel <= 3'b000;
        end else if (hReady) begin
            if (active) begin
                dataSel <= {uartSel, gpioSel, ramSel};
            end else begin
                dataSel <= 3'b000;  // Idle, nothing in the data phase
            end
        end
    end

    // ----------------------------------------
    // Response mux
    // ----------------------------------------
    always_comb begin
        hReady = 1'b1;    // Unmapped or idle slot
        hRData = 32'h0;
        if (dataSel[0]) begin
            hReady = ramRsp.hReadyOut;
            hRData = ramRsp.hRData;
        end else if (dataSel[1]) begin
            hReady = gpioRsp.hReadyOut;
            hRData = gpioRsp.hRData;
        end else if (dataSel[2]) begin
            hReady = uartRsp.hReadyOut;
            hRData = uartRsp.hRData;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ahblUartTx.sv
// AHB-Lite UART transmitter
// 8N1 frames at baudDiv clocks per bit; a data write while a frame is
// in flight is held off with wait states until the stop bit ends
`default_nettype none

module ahblUartTx import socPkg::*; #(
    parameter int baudDiv = 8
) (
    input  logic        HCLK,
    input  logic        arstN,
    input  ahbReq_t     busReq,
    input  logic [31:0] hWData,
    input  logic        sel,
    input  logic        hReady,
    output ahbRsp_t     rsp,
    output logic        uartTx
);

    localparam int cntBits = (baudDiv > 1) ? $clog2(baudDiv) : 1;

    logic               accept;
    logic               dataWrite;
    logic [7:0]         dataOff;
    logic               wrData;     // Data register write in its data phase
    logic               loadFrame;

    logic               busy;
    logic [9:0]         shiftReg;   // {stop, data[7:0], start}
    logic [3:0]         bitCnt;
    logic [cntBits-1:0] baudCnt;
    logic               baudTick;
    logic               frameDone;
    logic [31:0]        rdData;

    assign accept = sel && hReady && busReq.hTrans[1];

    // ----------------------------------------
    // Bus side
    // ----------------------------------------
    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            dataWrite <= 1'b0;
        end else if (hReady) begin
            dataWrite <= accept && busReq.hWrite;
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) dataOff <= busReq.hAddr[7:0];
    end

    assign wrData    = dataWrite && (dataOff == regUartData);
    assign loadFrame = wrData && hReady;

    // Stall a data write until the stop bit of the current frame is done
    assign baudTick  = (baudCnt == cntBits'(baudDiv - 1));
    assign frameDone = busy && (bitCnt == 4'd9) && baudTick;

    always_comb begin
        rdData = 32'h0;
        if (dataOff == regUartStatus) rdData = {31'h0, busy};
    end

    assign rsp = '{hRData: rdData, hReadyOut: !(wrData && busy) || frameDone};

    // ----------------------------------------
    // Shifter
    // ----------------------------------------
    always_ff @(posedge HCLK or negedge arstN) begin
        if (!arstN) begin
            busy     <= 1'b0;
            shiftReg <= 10'h3ff;
            bitCnt   <= 4'd0;
            baudCnt  <= '0;
        end else if (loadFrame) begin
            busy     <= 1'b1;  // Start bit goes out next cycle
            shiftReg <= {1'b1, hWData[7:0], 1'b0};
            bitCnt   <= 4'd0;
            baudCnt  <= '0;
        end else if (busy) begin
            if (baudTick) begin
                baudCnt  <= '0;
                shiftReg <= {1'b1, shiftReg[9:1]};  // LSB first
                bitCnt   <= bitCnt + 4'd1;
                if (bitCnt == 4'd9) busy <= 1'b0;
            end else begin
                baudCnt <= baudCnt + 1'b1;
            end
        end
    end

    assign uartTx = shiftReg[0];  // Line idles high

endmodule

`default_nettype wire

// File: hdl/hazardSoc.sv
// Peripheral subsystem top level
// One AHB-Lite master port feeding a splitter with RAM, GPIO and
// UART transmitter slaves
`default_nettype none

module hazardSoc import socPkg::*; #(
    parameter int ramWords = 1024,
    parameter int baudDiv  = 8
) (
    input  logic        HCLK,
    input  logic        arstN,
    input  ahbReq_t     busReq,
    input  logic [31:0] hWData,
    input  logic [31:0] gpioIn,
    output logic        hReady,
    output logic [31:0] hRData,
    output logic        uartTx,
    output logic [31:0] gpioOut,
    output logic [31:0] gpioOe
);

    // ----------------------------------------
    // Slave selects and responses
    // ----------------------------------------
    logic    ramSel;
    logic    gpioSel;
    logic    uartSel;
    ahbRsp_t ramRsp;
    ahbRsp_t gpioRsp;
    ahbRsp_t uartRsp;

    ahblSplitter i_splitter (
        .HCLK    (HCLK),
        .arstN   (arstN),
        .busReq  (busReq),
        .ramRsp  (ramRsp),
        .gpioRsp (gpioRsp),
        .uartRsp (uartRsp),
        .ramSel  (ramSel),
        .gpioSel (gpioSel),
        .uartSel (uartSel),
        .hReady  (hReady),
        .hRData  (hRData)
    );

    ahblRam #(.ramWords(ramWords)) i_ram (
        .HCLK   (HCLK),
        .arstN  (arstN),
        .busReq (busReq),
        .hWData (hWData),
        .sel    (ramSel),    // Slot 0x0
        .hReady (hReady),
        .rsp    (ramRsp)
    );

    ahblGpio i_gpio (
        .HCLK    (HCLK),
        .arstN   (arstN),
        .busReq  (busReq),
        .hWData  (hWData),
        .sel     (gpioSel),  // Slot 0x4
        .hReady  (hReady),
        .gpioIn  (gpioIn),
        .rsp     (gpioRsp),
        .gpioOut (gpioOut),
        .gpioOe  (gpioOe)
    );

    ahblUartTx #(.baudDiv(baudDiv)) i_uartTx (
        .HCLK   (HCLK),
        .arstN  (arstN),
        .busReq (busReq),
        .hWData (hWData),
        .sel    (uartSel),   // Slot 0x5
        .hReady (hReady),
        .rsp    (uartRsp),
        .uartTx (uartTx)
    );

endmodule

`default_nettype wire

// File: hdl/socPkg.sv
// SoC package
// AHB-Lite request and response structs, transfer encodings and the
// memory map of the peripheral subsystem
`default_nettype none

package socPkg;

    // ----------------------------------------
    // AHB-Lite encodings
    // ----------------------------------------
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } hTrans_t;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hSize_t;

    // Address phase from the master, 38 bits
    typedef struct packed {
        logic [31:0] hAddr;
        hTrans_t     hTrans;
        hSize_t      hSize;
        logic        hWrite;
    } ahbReq_t;

    // One slave's response, 33 bits
    typedef struct packed {
        logic [31:0] hRData;
        logic        hReadyOut;
    } ahbRsp_t;

    // ----------------------------------------
    // Memory map
    // ----------------------------------------
    localparam logic [3:0] slotRam  = 4'h0;  // HADDR[31:28]
    localparam logic [3:0] slotGpio = 4'h4;
    localparam logic [3:0] slotUart = 4'h5;

    localparam logic [7:0] regGpioOut    = 8'h00;
    localparam logic [7:0] regGpioOe     = 8'h04;
    localparam logic [7:0] regGpioIn     = 8'h08;
    localparam logic [7:0] regUartData   = 8'h00;
    localparam logic [7:0] regUartStatus = 8'h04;

endpackage

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Build the hazardSoc testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module hazardSocTb \
    -f hazardSoc.f -o simHazardSoc || { echo "Build failed"; exit 1; }

simOut=$(./obj_dir/simHazardSoc 2>&1)
echo "$simOut"
echo "$simOut" | grep -q "TESTBENCH PASSED" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
